// File: all.f
+incdir+.
backend_pkg.sv
id_stage.sv
scoreboard.sv
issue_read_operands.sv
ex_stage.sv
commit_stage.sv
issue_backend.sv
issue_backend_sva.sv
tb_issue_backend.sv

// File: backend_defs.svh
// ----------------------------------------------------------------------
// Size macros shared by the issue backend
// ----------------------------------------------------------------------
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// Data path width
`define XLEN 16
// Architectural registers, r0 included
`define NR_REGS 8
// Scoreboard depth and index width
`define NR_SB_ENTRIES 4
`define TRANS_ID_BITS 2
// Raw instruction buffer, equal to the initial upstream credits
`define IBUF_DEPTH 4
// Commit records the downstream can hold
`define COMMIT_CREDITS 2

`endif

// File: backend_pkg.sv
// ----------------------------------------------------------------------
// Opcode and unit encodings, index types, scoreboard entry
// ----------------------------------------------------------------------
`include "backend_defs.svh"

package backend_pkg;

  // Instruction opcodes, bits 15:13 of the word
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_ADDI = 3'd5,
    OP_MUL  = 3'd6,
    OP_NOP  = 3'd7
  } op_e;

  // Functional unit select
  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_e;

  typedef logic [$clog2(`NR_REGS)-1:0] reg_addr_t;
  typedef logic [`XLEN-1:0]            data_t;
  typedef logic [`TRANS_ID_BITS-1:0]   trans_id_t;

  // Decoded instruction as held in the scoreboard
  typedef struct packed {
    op_e       op;
    fu_e       fu;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
    logic      uses_rs2;
  } sb_entry_t;

endpackage

// File: commit_stage.sv
// ----------------------------------------------------------------------
// In-order commit under a downstream credit counter
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "backend_defs.svh"

module commit_stage (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   head_valid_i,
  input  logic                   head_done_i,
  input  backend_pkg::reg_addr_t head_rd_i,
  input  backend_pkg::data_t     head_result_i,
  output logic                   commit_ack_o,
  output logic                   rf_we_o,
  output backend_pkg::reg_addr_t rf_waddr_o,
  output backend_pkg::data_t     rf_wdata_o,
  output logic                   commit_valid_o,
  output backend_pkg::reg_addr_t commit_rd_o,
  output backend_pkg::data_t     commit_data_o,
  input  logic                   commit_credit_i
);
  localparam int CRED_W = $clog2(`COMMIT_CREDITS + 1);

  logic [CRED_W-1:0] credits_q;

  // Retire the head once it is done and the downstream has room
  assign commit_ack_o = head_valid_i & head_done_i & (credits_q != '0);
  assign rf_we_o      = commit_ack_o;
  assign rf_waddr_o   = head_rd_i;
  assign rf_wdata_o   = head_result_i;

  always_ff @(posedge clk_i) begin
    if (commit_ack_o) begin
      commit_rd_o   <= head_rd_i;
      commit_data_o <= head_result_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits_q      <= CRED_W'(`COMMIT_CREDITS);
      commit_valid_o <= 1'b0;
    end else begin
      credits_q      <= credits_q - CRED_W'(commit_ack_o) + CRED_W'(commit_credit_i);
      commit_valid_o <= commit_ack_o;
    end
  end

endmodule

// File: ex_stage.sv
// ----------------------------------------------------------------------
// One-cycle ALU and two-stage pipelined multiplier
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module ex_stage (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   alu_valid_i,
  input  logic                   mul_valid_i,
  input  backend_pkg::op_e       fu_op_i,
  input  backend_pkg::data_t     operand_a_i,
  input  backend_pkg::data_t     operand_b_i,
  input  backend_pkg::trans_id_t fu_trans_id_i,
  output logic                   alu_wb_valid_o,
  output backend_pkg::trans_id_t alu_wb_id_o,
  output backend_pkg::data_t     alu_wb_result_o,
  output logic                   mul_wb_valid_o,
  output backend_pkg::trans_id_t mul_wb_id_o,
  output backend_pkg::data_t     mul_wb_result_o
);
  import backend_pkg::*;

  data_t     alu_res;
  logic      mul_v1_q;
  trans_id_t mul_id1_q;
  data_t     mul_a_q, mul_b_q;

  // ALU function
  always_comb begin
    case (fu_op_i)
      OP_ADD, OP_ADDI: alu_res = operand_a_i + operand_b_i;
      OP_SUB:          alu_res = operand_a_i - operand_b_i;
      OP_AND:          alu_res = operand_a_i & operand_b_i;
      OP_OR:           alu_res = operand_a_i | operand_b_i;
      OP_XOR:          alu_res = operand_a_i ^ operand_b_i;
      // NOP hands rd back unchanged
      default:         alu_res = operand_a_i;
    endcase
  end

  // Result registers, payload only
  always_ff @(posedge clk_i) begin
    alu_wb_id_o     <= fu_trans_id_i;
    alu_wb_result_o <= alu_res;
    // Stage 1 latches operands, stage 2 keeps the low product half
    mul_id1_q       <= fu_trans_id_i;
    mul_a_q         <= operand_a_i;
    mul_b_q         <= operand_b_i;
    mul_wb_id_o     <= mul_id1_q;
    mul_wb_result_o <= mul_a_q * mul_b_q;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      alu_wb_valid_o <= 1'b0;
      mul_v1_q       <= 1'b0;
      mul_wb_valid_o <= 1'b0;
    end else begin
      alu_wb_valid_o <= alu_valid_i;
      mul_v1_q       <= mul_valid_i;
      mul_wb_valid_o <= mul_v1_q;
    end
  end

endmodule

// File: id_stage.sv
// ----------------------------------------------------------------------
// Raw instruction buffer with credit return, and instruction decoder
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "backend_defs.svh"

module id_stage (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  instr_valid_i,
  input  logic [15:0]           instr_i,
  output logic                  instr_credit_o,
  output logic                  decoded_valid_o,
  output backend_pkg::sb_entry_t decoded_entry_o,
  input  logic                  decoded_ack_i
);
  import backend_pkg::*;

  localparam int PTR_W = $clog2(`IBUF_DEPTH);
  localparam int CNT_W = $clog2(`IBUF_DEPTH + 1);

  logic [15:0]      buf_q [`IBUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [15:0]      word;
  logic             pop;

  // Upstream never sends without a credit, so no overflow check
  assign word            = buf_q[rd_ptr_q];
  assign decoded_valid_o = (count_q != '0);
  assign pop             = decoded_valid_o & decoded_ack_i;

  // Word layout: op | rd | rs1 | rs2 | imm4
  always_comb begin
    decoded_entry_o.op       = op_e'(word[15:13]);
    decoded_entry_o.rd       = word[12:10];
    decoded_entry_o.rs2      = word[6:4];
    decoded_entry_o.imm      = {{(`XLEN-4){word[3]}}, word[3:0]};
    decoded_entry_o.fu       = (decoded_entry_o.op == OP_MUL) ? FU_MUL : FU_ALU;
    decoded_entry_o.uses_rs2 = !(decoded_entry_o.op inside {OP_ADDI, OP_NOP});
    // NOP passes rd through the ALU, so it reads rd as rs1
    decoded_entry_o.rs1      = (decoded_entry_o.op == OP_NOP) ? word[12:10] : word[9:7];
  end

  // Payload ring
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      buf_q[wr_ptr_q] <= instr_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      count_q        <= '0;
      instr_credit_o <= 1'b0;
    end else begin
      if (instr_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q        <= count_q + CNT_W'(instr_valid_i) - CNT_W'(pop);
      // One credit back per word handed to the scoreboard
      instr_credit_o <= pop;
    end
  end

endmodule

// File: issue_backend.sv
// ----------------------------------------------------------------------
// Issue backend top: decode, scoreboard, issue, execute, commit
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "backend_defs.svh"

module issue_backend (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   instr_valid_i,
  input  logic [15:0]            instr_i,
  output logic                   instr_credit_o,
  output logic                   commit_valid_o,
  output backend_pkg::reg_addr_t commit_rd_o,
  output backend_pkg::data_t     commit_data_o,
  input  logic                   commit_credit_i
);
  import backend_pkg::*;

  // ------------------------------------------------------------------
  // Interconnect
  // ------------------------------------------------------------------
  // Decode to scoreboard
  logic      decoded_valid, decoded_ack;
  sb_entry_t decoded_entry;
  // Scoreboard to issue
  logic      issue_valid, issue_ack;
  sb_entry_t issue_entry;
  trans_id_t issue_id, commit_ptr;
  logic      [`NR_SB_ENTRIES-1:0] fwd_valid, fwd_done;
  reg_addr_t [`NR_SB_ENTRIES-1:0] fwd_rd;
  data_t     [`NR_SB_ENTRIES-1:0] fwd_result;
  // Issue to execute
  logic      alu_valid, mul_valid;
  op_e       fu_op;
  data_t     operand_a, operand_b;
  trans_id_t fu_trans_id;
  // Writeback
  logic      alu_wb_valid, mul_wb_valid;
  trans_id_t alu_wb_id, mul_wb_id;
  data_t     alu_wb_result, mul_wb_result;
  // Head and register file write
  logic      head_valid, head_done, commit_ack, rf_we;
  reg_addr_t head_rd, rf_waddr;
  data_t     head_result, rf_wdata;

  id_stage u_id_stage (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .instr_credit_o  (instr_credit_o),
    .decoded_valid_o (decoded_valid),
    .decoded_entry_o (decoded_entry),
    .decoded_ack_i   (decoded_ack)
  );

  scoreboard u_scoreboard (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .decoded_valid_i (decoded_valid),
    .decoded_entry_i (decoded_entry),
    .decoded_ack_o   (decoded_ack),
    .issue_valid_o   (issue_valid),
    .issue_entry_o   (issue_entry),
    .issue_id_o      (issue_id),
    .issue_ack_i     (issue_ack),
    .fwd_valid_o     (fwd_valid),
    .fwd_done_o      (fwd_done),
    .fwd_rd_o        (fwd_rd),
    .fwd_result_o    (fwd_result),
    .commit_ptr_o    (commit_ptr),
    .alu_wb_valid_i  (alu_wb_valid),
    .alu_wb_id_i     (alu_wb_id),
    .alu_wb_result_i (alu_wb_result),
    .mul_wb_valid_i  (mul_wb_valid),
    .mul_wb_id_i     (mul_wb_id),
    .mul_wb_result_i (mul_wb_result),
    .head_valid_o    (head_valid),
    .head_done_o     (head_done),
    .head_rd_o       (head_rd),
    .head_result_o   (head_result),
    .commit_ack_i    (commit_ack)
  );

  issue_read_operands u_issue_read_operands (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .issue_valid_i (issue_valid),
    .issue_entry_i (issue_entry),
    .issue_id_i    (issue_id),
    .issue_ack_o   (issue_ack),
    .fwd_valid_i   (fwd_valid),
    .fwd_done_i    (fwd_done),
    .fwd_rd_i      (fwd_rd),
    .fwd_result_i  (fwd_result),
    .commit_ptr_i  (commit_ptr),
    .rf_we_i       (rf_we),
    .rf_waddr_i    (rf_waddr),
    .rf_wdata_i    (rf_wdata),
    .alu_valid_o   (alu_valid),
    .mul_valid_o   (mul_valid),
    .fu_op_o       (fu_op),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .fu_trans_id_o (fu_trans_id)
  );

  ex_stage u_ex_stage (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .alu_valid_i     (alu_valid),
    .mul_valid_i     (mul_valid),
    .fu_op_i         (fu_op),
    .operand_a_i     (operand_a),
    .operand_b_i     (operand_b),
    .fu_trans_id_i   (fu_trans_id),
    .alu_wb_valid_o  (alu_wb_valid),
    .alu_wb_id_o     (alu_wb_id),
    .alu_wb_result_o (alu_wb_result),
    .mul_wb_valid_o  (mul_wb_valid),
    .mul_wb_id_o     (mul_wb_id),
    .mul_wb_result_o (mul_wb_result)
  );

  commit_stage u_commit_stage (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .head_valid_i    (head_valid),
    .head_done_i     (head_done),
    .head_rd_i       (head_rd),
    .head_result_i   (head_result),
    .commit_ack_o    (commit_ack),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata),
    .commit_valid_o  (commit_valid_o),
    .commit_rd_o     (commit_rd_o),
    .commit_data_o   (commit_data_o),
    .commit_credit_i (commit_credit_i)
  );

endmodule

// File: issue_backend_sva.sv
// ----------------------------------------------------------------------
// Assertions on instruction and commit credits, quiet outputs after reset
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "backend_defs.svh"

module issue_backend_sva (
  input logic clk_i,
  input logic arst_n_i,
  input logic instr_valid_i,
  input logic instr_credit_o,
  input logic commit_valid_o,
  input logic commit_credit_i
);

  // Records presented but not yet paid back by the downstream
  logic [3:0] outstanding_q;
  // Words sent and not yet given back as instruction credits
  logic [3:0] words_q;
  logic       sent_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= '0;
      words_q       <= '0;
      sent_q        <= 1'b0;
    end else begin
      outstanding_q <= outstanding_q + 4'(commit_valid_o) - 4'(commit_credit_i);
      words_q       <= words_q + 4'(instr_valid_i) - 4'(instr_credit_o);
      if (instr_valid_i) begin
        sent_q <= 1'b1;
      end
    end
  end

  // The record on the output now counts as outstanding too
  a_outstanding_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (outstanding_q + 4'(commit_valid_o)) <= 4'(`COMMIT_CREDITS))
    else $error("commit records outstanding beyond the downstream credits");

  a_credit_has_word: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_credit_o |-> words_q != 4'd0)
    else $error("instruction credit returned with no word outstanding");

  a_quiet_after_reset: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !sent_q |-> (!commit_valid_o && !instr_credit_o))
    else $error("output active before any instruction was sent");

endmodule

bind issue_backend issue_backend_sva u_issue_backend_sva (
  .clk_i           (clk_i),
  .arst_n_i        (arst_n_i),
  .instr_valid_i   (instr_valid_i),
  .instr_credit_o  (instr_credit_o),
  .commit_valid_o  (commit_valid_o),
  .commit_credit_i (commit_credit_i)
);

// File: issue_read_operands.sv
// ----------------------------------------------------------------------
// Register file, operand read with forwarding and stall, in-order issue
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "backend_defs.svh"

module issue_read_operands (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                                        issue_valid_i,
  input  backend_pkg::sb_entry_t                      issue_entry_i,
  input  backend_pkg::trans_id_t                      issue_id_i,
  output logic                                        issue_ack_o,
  input  logic                   [`NR_SB_ENTRIES-1:0] fwd_valid_i,
  input  logic                   [`NR_SB_ENTRIES-1:0] fwd_done_i,
  input  backend_pkg::reg_addr_t [`NR_SB_ENTRIES-1:0] fwd_rd_i,
  input  backend_pkg::data_t     [`NR_SB_ENTRIES-1:0] fwd_result_i,
  input  backend_pkg::trans_id_t                      commit_ptr_i,
  input  logic                                        rf_we_i,
  input  backend_pkg::reg_addr_t                      rf_waddr_i,
  input  backend_pkg::data_t                          rf_wdata_i,
  output logic                                        alu_valid_o,
  output logic                                        mul_valid_o,
  output backend_pkg::op_e                            fu_op_o,
  output backend_pkg::data_t                          operand_a_o,
  output backend_pkg::data_t                          operand_b_o,
  output backend_pkg::trans_id_t                      fu_trans_id_o
);
  import backend_pkg::*;

  data_t rf_q [`NR_REGS];
  data_t rs1_val, rs2_val;
  logic  rs1_busy, rs2_busy, stall;

  // Walk from the commit pointer up to the issuing slot, so the
  // last match is the youngest older writer of src
  function automatic void read_src(input reg_addr_t src, output data_t val,
                                   output logic busy);
    trans_id_t idx;
    logic      stop;
    val  = rf_q[src];
    busy = 1'b0;
    stop = 1'b0;
    for (int k = 0; k < `NR_SB_ENTRIES; k++) begin
      idx = commit_ptr_i + trans_id_t'(k);
      if (idx == issue_id_i) begin
        stop = 1'b1;
      end
      if (!stop && fwd_valid_i[idx] && (fwd_rd_i[idx] == src)) begin
        // Writer still in flight holds the issue
        busy = ~fwd_done_i[idx];
        val  = fwd_result_i[idx];
      end
    end
  endfunction

  always_comb begin
    read_src(issue_entry_i.rs1, rs1_val, rs1_busy);
    read_src(issue_entry_i.rs2, rs2_val, rs2_busy);
  end

  // rs2 only matters for register-register ops
  assign stall       = rs1_busy | (issue_entry_i.uses_rs2 & rs2_busy);
  assign issue_ack_o = issue_valid_i & ~stall;

  // Both units always ready
  assign alu_valid_o   = issue_ack_o & (issue_entry_i.fu == FU_ALU);
  assign mul_valid_o   = issue_ack_o & (issue_entry_i.fu == FU_MUL);
  assign fu_op_o       = issue_entry_i.op;
  assign operand_a_o   = rs1_val;
  assign operand_b_o   = issue_entry_i.uses_rs2 ? rs2_val : issue_entry_i.imm;
  assign fu_trans_id_o = issue_id_i;

  // Architectural state, written only at commit
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < `NR_REGS; r++) begin
        rf_q[r] <= '0;
      end
    end else if (rf_we_i) begin
      rf_q[rf_waddr_i] <= rf_wdata_i;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the issue backend testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_issue_backend \
  -f all.f -o sim_issue_backend \
  && ./obj_dir/sim_issue_backend > sim.log 2>&1 \
  || echo "CHECKS FAILED" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

// File: scoreboard.sv
// ----------------------------------------------------------------------
// Circular scoreboard: allocate, issue, writeback, forward, commit head
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "backend_defs.svh"

module scoreboard (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  // Decode side
  input  logic                                            decoded_valid_i,
  input  backend_pkg::sb_entry_t                          decoded_entry_i,
  output logic                                            decoded_ack_o,
  // Issue side
  output logic                                            issue_valid_o,
  output backend_pkg::sb_entry_t                          issue_entry_o,
  output backend_pkg::trans_id_t                          issue_id_o,
  input  logic                                            issue_ack_i,
  // Per entry forwarding state
  output logic                 [`NR_SB_ENTRIES-1:0]       fwd_valid_o,
  output logic                 [`NR_SB_ENTRIES-1:0]       fwd_done_o,
  output backend_pkg::reg_addr_t [`NR_SB_ENTRIES-1:0]     fwd_rd_o,
  output backend_pkg::data_t   [`NR_SB_ENTRIES-1:0]       fwd_result_o,
  output backend_pkg::trans_id_t                          commit_ptr_o,
  // Writeback ports
  input  logic                                            alu_wb_valid_i,
  input  backend_pkg::trans_id_t                          alu_wb_id_i,
  input  backend_pkg::data_t                              alu_wb_result_i,
  input  logic                                            mul_wb_valid_i,
  input  backend_pkg::trans_id_t                          mul_wb_id_i,
  input  backend_pkg::data_t                              mul_wb_result_i,
  // Commit head
  output logic                                            head_valid_o,
  output logic                                            head_done_o,
  output backend_pkg::reg_addr_t                          head_rd_o,
  output backend_pkg::data_t                              head_result_o,
  input  logic                                            commit_ack_i
);
  import backend_pkg::*;

  sb_entry_t entry_q  [`NR_SB_ENTRIES];
  data_t     result_q [`NR_SB_ENTRIES];
  logic [`NR_SB_ENTRIES-1:0] valid_q, issued_q, done_q;
  trans_id_t alloc_ptr_q, issue_ptr_q, commit_ptr_q;
  logic      alloc, issue_fire;

  // ------------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------------
  // Full when the next allocation slot is still occupied
  assign decoded_ack_o = ~valid_q[alloc_ptr_q];
  assign alloc         = decoded_valid_i & decoded_ack_o;

  // Oldest unissued entry sits at the issue pointer
  assign issue_valid_o = valid_q[issue_ptr_q] & ~issued_q[issue_ptr_q];
  assign issue_entry_o = entry_q[issue_ptr_q];
  assign issue_id_o    = issue_ptr_q;
  assign issue_fire    = issue_valid_o & issue_ack_i;

  // Forwarding view of every slot
  assign fwd_valid_o  = valid_q;
  assign fwd_done_o   = done_q;
  assign commit_ptr_o = commit_ptr_q;
  always_comb begin
    for (int i = 0; i < `NR_SB_ENTRIES; i++) begin
      fwd_rd_o[i]     = entry_q[i].rd;
      fwd_result_o[i] = result_q[i];
    end
  end

  // Commit head
  assign head_valid_o  = valid_q[commit_ptr_q];
  assign head_done_o   = done_q[commit_ptr_q];
  assign head_rd_o     = entry_q[commit_ptr_q].rd;
  assign head_result_o = result_q[commit_ptr_q];

  // ------------------------------------------------------------------
  // State
  // ------------------------------------------------------------------
  // Payload by index
  always_ff @(posedge clk_i) begin
    if (alloc) begin
      entry_q[alloc_ptr_q] <= decoded_entry_i;
    end
    if (alu_wb_valid_i) begin
      result_q[alu_wb_id_i] <= alu_wb_result_i;
    end
    if (mul_wb_valid_i) begin
      result_q[mul_wb_id_i] <= mul_wb_result_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q      <= '0;
      issued_q     <= '0;
      done_q       <= '0;
      alloc_ptr_q  <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
    end else begin
      if (alloc) begin
        valid_q[alloc_ptr_q]  <= 1'b1;
        issued_q[alloc_ptr_q] <= 1'b0;
        done_q[alloc_ptr_q]   <= 1'b0;
        alloc_ptr_q           <= alloc_ptr_q + 1'b1;
      end
      if (issue_fire) begin
        issued_q[issue_ptr_q] <= 1'b1;
        issue_ptr_q           <= issue_ptr_q + 1'b1;
      end
      // Both units may finish in the same cycle, on different slots
      if (alu_wb_valid_i) begin
        done_q[alu_wb_id_i] <= 1'b1;
      end
      if (mul_wb_valid_i) begin
        done_q[mul_wb_id_i] <= 1'b1;
      end
      if (commit_ack_i) begin
        valid_q[commit_ptr_q] <= 1'b0;
        commit_ptr_q          <= commit_ptr_q + 1'b1;
      end
    end
  end

endmodule

// File: tb_issue_backend.sv
// ----------------------------------------------------------------------
// Testbench for the issue backend: LCG stimulus, credit consumer,
// reference register model and commit checks
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "backend_defs.svh"

module tb_issue_backend;
  import backend_pkg::*;

  localparam int N_INSTR        = 200;
  localparam int TIMEOUT_CYCLES = N_INSTR * 12 + 100;

  logic        clk_i;
  logic        arst_n_i;
  logic        instr_valid_i;
  logic [15:0] instr_i;
  logic        instr_credit_o;
  logic        commit_valid_o;
  reg_addr_t   commit_rd_o;
  data_t       commit_data_o;
  logic        commit_credit_i;

  // Stimulus, consumer and model state
  logic [31:0] rng_state;
  data_t       model_regs [`NR_REGS];
  reg_addr_t   exp_rd_q [$];
  data_t       exp_data_q [$];
  int          release_q [$];
  int          cycle_cnt = 0;
  int          credits;
  int          credits_back;
  int          sent;
  int          commits;

  issue_backend u_issue_backend (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .instr_credit_o  (instr_credit_o),
    .commit_valid_o  (commit_valid_o),
    .commit_rd_o     (commit_rd_o),
    .commit_data_o   (commit_data_o),
    .commit_credit_i (commit_credit_i)
  );

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: %0d of %0d commits seen after %0d cycles", commits, N_INSTR,
               cycle_cnt);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped by cycle limit");
    end
  end

  // ------------------------------------------------------------------
  // Random source and reference model
  // ------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    // Upper bits have the longer period
    return {8'h00, rng_state[31:8]};
  endfunction

  // Mostly r0..r3, so writers and readers collide often
  function automatic reg_addr_t pick_reg();
    logic [31:0] r;
    r = next_rand();
    if (r[3:0] < 4'd12) begin
      return {1'b0, r[5:4]};
    end else begin
      return r[6:4];
    end
  endfunction

  function automatic logic [15:0] gen_word();
    logic [31:0] r;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    r   = next_rand();
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    return {r[2:0], rd, rs1, rs2, r[7:4]};
  endfunction

  // In-order execution of one word, result queued for the commit check
  function automatic void model_exec(input logic [15:0] w);
    reg_addr_t rd;
    data_t     a;
    data_t     b;
    data_t     res;
    rd = w[12:10];
    a  = model_regs[w[9:7]];
    b  = model_regs[w[6:4]];
    case (op_e'(w[15:13]))
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_ADDI: res = a + {{(`XLEN-4){w[3]}}, w[3:0]};
      // Low half of the product
      OP_MUL:  res = a * b;
      default: res = model_regs[rd];
    endcase
    model_regs[rd] = res;
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(res);
  endfunction

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s (time %0t)", msg, $time);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_rd(input reg_addr_t act, input reg_addr_t exp);
    if (act !== exp) begin
      $display("error at %0t: commit_rd_o = %0d, expected %0d", $time, act, exp);
      $display("CHECKS FAILED");
      $fatal(1, "register number mismatch");
    end
  endtask

  task automatic check_data(input data_t act, input data_t exp);
    if (act !== exp) begin
      $display("error at %0t: commit_data_o = 0x%04h, expected 0x%04h", $time, act, exp);
      $display("CHECKS FAILED");
      $fatal(1, "commit data mismatch");
    end
  endtask

  // One falling edge: sample outputs, run the consumer, drive the upstream
  task automatic cycle_step();
    logic [15:0] word;
    if (instr_credit_o) begin
      credits++;
      credits_back++;
      if (credits > `IBUF_DEPTH) begin
        abort_run("more instruction credits returned than words sent");
      end
    end
    if (commit_valid_o) begin
      if (exp_rd_q.size() == 0) begin
        abort_run("commit seen with no instruction outstanding");
      end else begin
        check_rd(commit_rd_o, exp_rd_q.pop_front());
        check_data(commit_data_o, exp_data_q.pop_front());
        commits++;
        release_q.push_back(cycle_cnt + int'(next_rand() % 6));
      end
    end
    // Consumer frees at most one record per cycle, oldest first
    commit_credit_i = 1'b0;
    if (release_q.size() != 0 && release_q[0] <= cycle_cnt) begin
      void'(release_q.pop_front());
      commit_credit_i = 1'b1;
    end
    instr_valid_i = 1'b0;
    if (sent < N_INSTR && credits > 0 && next_rand() % 8 != 0) begin
      word = gen_word();
      model_exec(word);
      instr_i       = word;
      instr_valid_i = 1'b1;
      credits--;
      sent++;
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    clk_i           = 1'b0;
    arst_n_i        = 1'b0;
    instr_valid_i   = 1'b0;
    instr_i         = '0;
    commit_credit_i = 1'b0;
    rng_state       = 32'hbe26;
    credits         = `IBUF_DEPTH;
    credits_back    = 0;
    sent            = 0;
    commits         = 0;
    for (int r = 0; r < `NR_REGS; r++) begin
      model_regs[r] = '0;
    end
    // Reset held for 4 cycles
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    while (commits < N_INSTR) begin
      @(negedge clk_i);
      cycle_step();
    end
    // Extra cycles expose stray commits or late credits
    repeat (10) begin
      @(negedge clk_i);
      cycle_step();
    end
    if (sent == N_INSTR && commits == N_INSTR && credits_back == N_INSTR) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("wrong totals: %0d sent, %0d committed, %0d instruction credits back",
               sent, commits, credits_back);
      $display("CHECKS FAILED");
      $fatal(1, "totals mismatch");
    end
  end

endmodule
